//--- sources.f
hw/cachePkg.sv
hw/tagStore.sv
hw/dataStore.sv
hw/cacheController.sv
hw/cacheTop.sv
test/memoryModel.sv
test/cacheTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module cacheTb -o simv &&
./obj_dir/simv || exit 1

//--- test/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  import cachePkg::*;

  localparam int totalRequests = 206;   // 6 directed plus 200 random

  logic clk = 1'b0;
  logic reset;
  logic cpuReqValid;
  logic cpuReqReady;
  cpuAddrT cpuReqAddr;
  cpuWordT cpuReqData;
  byteMaskT cpuReqWrite;
  logic cpuRespValid;
  cpuWordT cpuRespData;
  logic memReqValid;
  logic memReqReady;
  memAddrT memReqAddr;
  logic memReqRw;
  logic memReqDataValid;
  logic memReqDataReady;
  memBeatT memReqDataBits;
  memMaskT memReqDataMask;
  logic memRespValid;
  memBeatT memRespData;

  cpuWordT modelMem [cpuAddrT];   // Expected memory contents by word
  memAddrT readAddrQ[$];
  memAddrT writeAddrQ[$];
  memBeatT writeDataQ[$];
  memMaskT writeMaskQ[$];

  cacheTop #(.numLines(8)) uut (.*);

  memoryModel memory (.*);

  always #10 clk = ~clk;

  // Memory traffic log
  always @(posedge clk) begin
    if (!reset && memReqValid && memReqReady) begin
      if (memReqRw) writeAddrQ.push_back(memReqAddr);
      else readAddrQ.push_back(memReqAddr);
    end
    if (!reset && memReqDataValid && memReqDataReady) begin
      writeDataQ.push_back(memReqDataBits);
      writeMaskQ.push_back(memReqDataMask);
    end
  end

  initial begin
    repeat (totalRequests * 200) @(posedge clk);
    $display("Timeout: the cache stopped answering requests");
    $display("Testbench failed");
    $fatal(1);
  end

  function automatic cpuAddrT makeAddr(int tag, int idx, int beat, int word);
    return cpuAddrT'((tag << 7) | (idx << 4) | (beat << 2) | word);
  endfunction

  function automatic cpuWordT predict(cpuAddrT a);
    if (modelMem.exists(a)) return modelMem[a];
    return 32'(a) ^ 32'hA5A5_0000;   // Never written
  endfunction

  task automatic expectEqual(logic [127:0] got, logic [127:0] exp, string msg);
    assert (got == exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic clearLog();
    readAddrQ.delete();
    writeAddrQ.delete();
    writeDataQ.delete();
    writeMaskQ.delete();
  endtask

  // One CPU request, returns read data and edges until the response
  task automatic issueRequest(cpuAddrT addr, cpuWordT data, byteMaskT mask,
                              output cpuWordT rdata, output int latency);
    cpuWordT merged;
    @(negedge clk);
    while (!cpuReqReady) @(negedge clk);
    @(posedge clk);
    cpuReqValid <= 1'b1;
    cpuReqAddr <= addr;
    cpuReqData <= data;
    cpuReqWrite <= mask;
    @(posedge clk);   // Accepted here
    cpuReqValid <= 1'b0;
    latency = 0;
    rdata = '0;
    if (mask == 0) begin
      do begin
        @(negedge clk);
        latency++;
      end while (!cpuRespValid);
      rdata = cpuRespData;
      expectEqual(128'(cpuReqReady), 128'(1), "ready with read response");
    end else begin
      merged = predict(addr);
      for (int k = 0; k < 4; k++) begin
        if (mask[k]) merged[k*8 +: 8] = data[k*8 +: 8];
      end
      modelMem[addr] = merged;
    end
    // No response on writes, and read responses last one cycle
    do begin
      @(negedge clk);
      expectEqual(128'(cpuRespValid), 128'(0), "unexpected response pulse");
    end while (!cpuReqReady);   // Write done once ready returns
  endtask

  task automatic readCheck(cpuAddrT addr, string msg, output int latency);
    cpuWordT got;
    issueRequest(addr, '0, '0, got, latency);
    expectEqual(128'(got), 128'(predict(addr)), msg);
  endtask

  task automatic coldReadMiss();
    int lat;
    clearLog();
    readCheck(makeAddr(5, 3, 2, 1), "cold read data", lat);
    expectEqual(128'(readAddrQ.size()), 128'(4), "cold miss read beats");
    expectEqual(128'(writeAddrQ.size()), 128'(0), "cold miss write beats");
    for (int b = 0; b < 4; b++) begin
      expectEqual(128'(readAddrQ[b]), 128'(makeAddr(5, 3, b, 0) >> 2), "fill address");
    end
  endtask

  task automatic readHit();
    int lat;
    clearLog();
    readCheck(makeAddr(5, 3, 0, 3), "hit read data", lat);
    expectEqual(128'(lat), 128'(3), "hit response latency");   // Valid after edge N+2
    expectEqual(128'(readAddrQ.size() + writeAddrQ.size()), 128'(0), "hit memory traffic");
  endtask

  task automatic maskedWriteHit();
    cpuWordT unused;
    int lat;
    clearLog();
    issueRequest(makeAddr(5, 3, 1, 2), 32'h1234_5678, 4'b0101, unused, lat);
    readCheck(makeAddr(5, 3, 1, 2), "masked write readback", lat);
    expectEqual(128'(readAddrQ.size() + writeAddrQ.size()), 128'(0),
                "write hit memory traffic");
  endtask

  task automatic dirtyEviction();
    int lat;
    clearLog();
    readCheck(makeAddr(9, 3, 3, 0), "conflict read data", lat);
    expectEqual(128'(writeAddrQ.size()), 128'(4), "writeback beats");
    expectEqual(128'(writeDataQ.size()), 128'(4), "writeback data beats");
    expectEqual(128'(readAddrQ.size()), 128'(4), "refill beats");
    for (int b = 0; b < 4; b++) begin
      expectEqual(128'(writeAddrQ[b]), 128'(makeAddr(5, 3, b, 0) >> 2), "writeback address");
      expectEqual(128'(writeMaskQ[b]), 128'(16'hFFFF), "writeback mask");
      for (int w = 0; w < 4; w++) begin
        expectEqual(128'(writeDataQ[b][w*32 +: 32]), 128'(predict(makeAddr(5, 3, b, w))),
                    "writeback data");
      end
    end
    // Old line back in, victim is clean now
    clearLog();
    readCheck(makeAddr(5, 3, 1, 2), "evicted data reread", lat);
    expectEqual(128'(writeAddrQ.size()), 128'(0), "clean conflict write beats");
  endtask

  task automatic randomMix();
    cpuAddrT addr;
    cpuWordT unused;
    int lat;
    for (int n = 0; n < 200; n++) begin
      addr = makeAddr(1 + int'($urandom % 3), int'($urandom % 4), int'($urandom % 4),
                      int'($urandom % 4));
      if ($urandom % 2) begin
        issueRequest(addr, $urandom, byteMaskT'(1 + $urandom % 15), unused, lat);
      end else begin
        readCheck(addr, "random read", lat);
      end
    end
  endtask

  initial begin
    void'($urandom(24));
    reset <= 1'b1;
    cpuReqValid <= 1'b0;
    cpuReqAddr <= '0;
    cpuReqData <= '0;
    cpuReqWrite <= '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    coldReadMiss();
    readHit();
    maskedWriteHit();
    dirtyEviction();
    randomMix();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- test/memoryModel.sv
`timescale 1ns/1ps

module memoryModel (
  input  logic              clk,
  input  logic              reset,
  input  logic              memReqValid,
  output logic              memReqReady,
  input  cachePkg::memAddrT memReqAddr,
  input  logic              memReqRw,
  input  logic              memReqDataValid,
  output logic              memReqDataReady,
  input  cachePkg::memBeatT memReqDataBits,
  input  cachePkg::memMaskT memReqDataMask,
  output logic              memRespValid,
  output cachePkg::memBeatT memRespData
);

  import cachePkg::*;

  memBeatT mem [memAddrT];   // Sparse, only written beats
  memAddrT wrAddr;
  memAddrT rdAddr;
  memBeatT wrData;
  memMaskT wrMask;
  logic haveAddr;   // Write address phase seen
  logic haveData;   // Write data phase seen
  int respDelay;

  // Unwritten words read as their word address XOR a fixed pattern
  function automatic memBeatT readBeat(memAddrT a);
    memBeatT b;
    if (mem.exists(a)) begin
      return mem[a];
    end
    for (int i = 0; i < 4; i++) begin
      b[i*32 +: 32] = 32'({a, 2'(i)}) ^ 32'hA5A5_0000;
    end
    return b;
  endfunction

  always @(posedge clk) begin : step
    logic gotAddr;
    logic gotData;
    memAddrT a;
    memBeatT d;
    memBeatT merged;
    memMaskT m;
    if (reset) begin
      memReqReady <= 1'b0;
      memReqDataReady <= 1'b0;
      memRespValid <= 1'b0;
      respDelay <= 0;
      haveAddr <= 1'b0;
      haveData <= 1'b0;
    end else begin
      gotAddr = haveAddr;
      gotData = haveData;
      a = wrAddr;
      d = wrData;
      m = wrMask;
      if (memReqValid && memReqReady) begin
        if (memReqRw) begin
          gotAddr = 1'b1;
          a = memReqAddr;
        end else begin
          rdAddr <= memReqAddr;
          respDelay <= 1 + int'($urandom % 4);   // 1 to 4 cycles
        end
      end
      if (memReqDataValid && memReqDataReady) begin
        gotData = 1'b1;
        d = memReqDataBits;
        m = memReqDataMask;
      end
      if (gotAddr && gotData) begin   // Both phases in, commit beat
        merged = readBeat(a);
        for (int k = 0; k < 16; k++) begin
          if (m[k]) merged[k*8 +: 8] = d[k*8 +: 8];
        end
        mem[a] = merged;
        haveAddr <= 1'b0;
        haveData <= 1'b0;
      end else begin
        haveAddr <= gotAddr;
        haveData <= gotData;
        wrAddr <= a;
        wrData <= d;
        wrMask <= m;
      end
      memRespValid <= 1'b0;
      if (respDelay > 0) begin
        respDelay <= respDelay - 1;
        if (respDelay == 1) begin
          memRespValid <= 1'b1;
          memRespData <= readBeat(rdAddr);
        end
      end
      memReqReady <= ($urandom % 4) != 0;       // Random stalls
      memReqDataReady <= ($urandom % 4) != 0;
    end
  end

endmodule

//--- hw/cacheTop.sv
`timescale 1ns/1ps

module cacheTop #(
  parameter int numLines = cachePkg::defaultNumLines,
  localparam int indexWidth = $clog2(numLines),
  localparam int tagWidth = cachePkg::cpuAddrWidth - cachePkg::offsetWidth - indexWidth,
  localparam int wordAddrWidth = indexWidth + cachePkg::offsetWidth,
  localparam int beatAddrWidth = indexWidth + cachePkg::beatSelWidth
) (
  input  logic              clk,
  input  logic              reset,
  // CPU word port
  input  logic              cpuReqValid,
  output logic              cpuReqReady,
  input  cachePkg::cpuAddrT cpuReqAddr,
  input  cachePkg::cpuWordT cpuReqData,
  input  cachePkg::byteMaskT cpuReqWrite,
  output logic              cpuRespValid,
  output cachePkg::cpuWordT cpuRespData,
  // Memory beat port
  output logic              memReqValid,
  input  logic              memReqReady,
  output cachePkg::memAddrT memReqAddr,
  output logic              memReqRw,
  output logic              memReqDataValid,
  input  logic              memReqDataReady,
  output cachePkg::memBeatT memReqDataBits,
  output cachePkg::memMaskT memReqDataMask,
  input  logic              memRespValid,
  input  cachePkg::memBeatT memRespData
);

  import cachePkg::*;

  // Tag store side
  logic [indexWidth-1:0] lineIndex;
  logic [tagWidth-1:0] reqTag;
  logic [tagWidth-1:0] victimTag;
  logic hit;
  logic victimValidDirty;
  logic tagUpdate;
  logic markDirty;

  // Data store side
  logic [wordAddrWidth-1:0] wordAddr;
  logic wordWrite;
  byteMaskT wordMask;
  cpuWordT wordWriteData;
  cpuWordT wordReadData;
  logic [beatAddrWidth-1:0] beatAddr;
  logic beatWrite;
  memBeatT beatWriteData;
  memBeatT beatReadData;

  // Port names match the wires above one to one
  cacheController #(.numLines(numLines)) controller (.*);

  tagStore #(.numLines(numLines)) tags (
    .clk              (clk),
    .reset            (reset),
    .lineIndex        (lineIndex),
    .reqTag           (reqTag),
    .tagUpdate        (tagUpdate),
    .markDirty        (markDirty),
    .hit              (hit),
    .victimValidDirty (victimValidDirty),
    .victimTag        (victimTag)
  );

  dataStore #(.numLines(numLines)) data (
    .clk           (clk),
    .wordAddr      (wordAddr),
    .wordWrite     (wordWrite),
    .wordMask      (wordMask),
    .wordWriteData (wordWriteData),
    .wordReadData  (wordReadData),
    .beatAddr      (beatAddr),
    .beatWrite     (beatWrite),
    .beatWriteData (beatWriteData),
    .beatReadData  (beatReadData)
  );

endmodule

//--- hw/cacheController.sv
`timescale 1ns/1ps

module cacheController #(
  parameter int numLines = cachePkg::defaultNumLines,
  localparam int indexWidth = $clog2(numLines),
  localparam int tagWidth = cachePkg::cpuAddrWidth - cachePkg::offsetWidth - indexWidth,
  localparam int wordAddrWidth = indexWidth + cachePkg::offsetWidth,
  localparam int beatAddrWidth = indexWidth + cachePkg::beatSelWidth
) (
  input  logic                     clk,
  input  logic                     reset,
  // CPU port
  input  logic                     cpuReqValid,
  output logic                     cpuReqReady,
  input  cachePkg::cpuAddrT        cpuReqAddr,
  input  cachePkg::cpuWordT        cpuReqData,
  input  cachePkg::byteMaskT       cpuReqWrite,
  output logic                     cpuRespValid,
  output cachePkg::cpuWordT        cpuRespData,
  // Memory port
  output logic                     memReqValid,
  input  logic                     memReqReady,
  output cachePkg::memAddrT        memReqAddr,
  output logic                     memReqRw,
  output logic                     memReqDataValid,
  input  logic                     memReqDataReady,
  output cachePkg::memBeatT        memReqDataBits,
  output cachePkg::memMaskT        memReqDataMask,
  input  logic                     memRespValid,
  input  cachePkg::memBeatT        memRespData,
  // Tag store
  output logic [indexWidth-1:0]    lineIndex,
  output logic [tagWidth-1:0]      reqTag,
  input  logic                     hit,
  input  logic                     victimValidDirty,
  input  logic [tagWidth-1:0]      victimTag,
  output logic                     tagUpdate,
  output logic                     markDirty,
  // Data store
  output logic [wordAddrWidth-1:0] wordAddr,
  output logic                     wordWrite,
  output cachePkg::byteMaskT       wordMask,
  output cachePkg::cpuWordT        wordWriteData,
  input  cachePkg::cpuWordT        wordReadData,
  output logic [beatAddrWidth-1:0] beatAddr,
  output logic                     beatWrite,
  output cachePkg::memBeatT        beatWriteData,
  input  cachePkg::memBeatT        beatReadData
);

  import cachePkg::*;

  localparam beatIndexT lastBeat = beatIndexT'(beatsPerLine - 1);

  ctrlStateT state;
  cpuAddrT reqAddr;    // Held request
  cpuWordT reqData;
  byteMaskT reqMask;
  beatIndexT beatCount;   // Shared by writeback and fill loops
  logic addrDone;         // Writeback address phase already taken
  logic dataDone;         // Writeback data phase already taken

  logic [indexWidth-1:0] reqIndex;
  logic addrFire;
  logic dataFire;
  logic beatSent;

  assign reqIndex = reqAddr[offsetWidth +: indexWidth];
  assign reqTag = reqAddr[cpuAddrWidth-1 -: tagWidth];

  // Early lookup in idle, held index everywhere else
  assign lineIndex = (state == idle) ? cpuReqAddr[offsetWidth +: indexWidth] : reqIndex;
  assign cpuReqReady = state == idle;

  // Word port always points at the held request
  assign wordAddr = reqAddr[wordAddrWidth-1:0];
  assign wordMask = reqMask;
  assign wordWriteData = reqData;
  assign wordWrite = (state == tagCheck) && hit && (|reqMask);
  assign markDirty = wordWrite;   // Same edge as the byte write

  // Beat port, fill writes come straight from the response
  assign beatAddr = {reqIndex, beatCount};
  assign beatWrite = (state == fillWait) && memRespValid;
  assign beatWriteData = memRespData;
  assign tagUpdate = beatWrite && (beatCount == lastBeat);   // Last fill beat

  // Memory request, held stable by state and done flags
  assign memReqRw = state == writebackSend;
  assign memReqValid = (state == fillRequest) || (memReqRw && !addrDone);
  assign memReqDataValid = memReqRw && !dataDone;
  assign memReqDataBits = beatReadData;   // Registered read stays put in writebackSend
  assign memReqDataMask = '1;             // Full beats only
  assign memReqAddr = memReqRw ? {victimTag, reqIndex, beatCount}
                               : {reqTag, reqIndex, beatCount};

  assign addrFire = memReqValid && memReqReady;
  assign dataFire = memReqDataValid && memReqDataReady;
  // Both phases done, possibly on different edges
  assign beatSent = (addrDone || addrFire) && (dataDone || dataFire);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      beatCount <= '0;
      addrDone <= 1'b0;
      dataDone <= 1'b0;
      cpuRespValid <= 1'b0;
    end else begin
      cpuRespValid <= 1'b0;   // One-cycle pulse
      case (state)
        idle: begin
          if (cpuReqValid) begin
            state <= relookup;
          end
        end
        relookup: state <= tagCheck;   // Tag and word reads at held address
        tagCheck: begin
          beatCount <= '0;
          if (hit) begin
            cpuRespValid <= ~|reqMask;   // Reads only
            state <= idle;
          end else if (victimValidDirty) begin
            state <= writebackRead;
          end else begin
            state <= fillRequest;   // Clean or empty victim
          end
        end
        writebackRead: state <= writebackSend;
        writebackSend: begin
          if (beatSent) begin
            addrDone <= 1'b0;
            dataDone <= 1'b0;
            beatCount <= beatCount + beatIndexT'(1);   // Wraps to 0 for the fill
            state <= (beatCount == lastBeat) ? fillRequest : writebackRead;
          end else begin
            addrDone <= addrDone || addrFire;
            dataDone <= dataDone || dataFire;
          end
        end
        fillRequest: begin
          if (memReqReady) begin
            state <= fillWait;
          end
        end
        fillWait: begin
          if (memRespValid) begin
            beatCount <= beatCount + beatIndexT'(1);
            state <= (beatCount == lastBeat) ? relookup : fillRequest;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk) begin
    if (cpuReqValid && cpuReqReady) begin
      reqAddr <= cpuReqAddr;
      reqData <= cpuReqData;
      reqMask <= cpuReqWrite;
    end
    if (state == tagCheck && hit) begin
      cpuRespData <= wordReadData;
    end
  end

endmodule

//--- hw/dataStore.sv
`timescale 1ns/1ps

module dataStore #(
  parameter int numLines = cachePkg::defaultNumLines,
  localparam int indexWidth = $clog2(numLines),
  localparam int wordAddrWidth = indexWidth + cachePkg::offsetWidth,
  localparam int beatAddrWidth = indexWidth + cachePkg::beatSelWidth
) (
  input  logic                     clk,
  // CPU word port
  input  logic [wordAddrWidth-1:0] wordAddr,
  input  logic                     wordWrite,
  input  cachePkg::byteMaskT       wordMask,
  input  cachePkg::cpuWordT        wordWriteData,
  output cachePkg::cpuWordT        wordReadData,
  // Memory beat port
  input  logic [beatAddrWidth-1:0] beatAddr,
  input  logic                     beatWrite,
  input  cachePkg::memBeatT        beatWriteData,
  output cachePkg::memBeatT        beatReadData
);

  import cachePkg::*;

  localparam int bankDepth = numLines * beatsPerLine;   // One entry per beat

  // One bank per word position in a beat
  cpuWordT bankMem [wordsPerBeat][bankDepth];

  logic [wordSelWidth-1:0] wordSel;
  logic [beatAddrWidth-1:0] wordEntry;

  assign wordSel = wordAddr[wordSelWidth-1:0];
  assign wordEntry = wordAddr[wordAddrWidth-1:wordSelWidth];

  always_ff @(posedge clk) begin
    for (int b = 0; b < wordsPerBeat; b++) begin
      if (beatWrite) begin
        bankMem[b][beatAddr] <= beatWriteData[b*cpuWordWidth +: cpuWordWidth];
      end else if (wordWrite && int'(wordSel) == b) begin
        for (int k = 0; k < cpuWordWidth/8; k++) begin
          if (wordMask[k]) begin
            bankMem[b][wordEntry][k*8 +: 8] <= wordWriteData[k*8 +: 8];   // Byte lane
          end
        end
      end
      // All four banks read at the same entry
      beatReadData[b*cpuWordWidth +: cpuWordWidth] <= bankMem[b][beatAddr];
    end
    wordReadData <= bankMem[wordSel][wordEntry];   // Old data on a same-edge write
  end

endmodule

//--- hw/tagStore.sv
`timescale 1ns/1ps

module tagStore #(
  parameter int numLines = cachePkg::defaultNumLines,
  localparam int indexWidth = $clog2(numLines),
  localparam int tagWidth = cachePkg::cpuAddrWidth - cachePkg::offsetWidth - indexWidth
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [indexWidth-1:0] lineIndex,
  input  logic [tagWidth-1:0]   reqTag,
  input  logic                  tagUpdate,   // Install reqTag, valid and clean
  input  logic                  markDirty,
  output logic                  hit,
  output logic                  victimValidDirty,
  output logic [tagWidth-1:0]   victimTag
);

  logic [tagWidth-1:0] tagMem [numLines];
  logic [numLines-1:0] validBits;
  logic [numLines-1:0] dirtyBits;
  logic validQ;   // Registered entry state
  logic dirtyQ;

  // Tag array and its registered read
  always_ff @(posedge clk) begin
    if (tagUpdate) begin
      tagMem[lineIndex] <= reqTag;
    end
    victimTag <= tagMem[lineIndex];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      validQ <= 1'b0;
      dirtyQ <= 1'b0;
    end else begin
      if (tagUpdate) begin
        validBits[lineIndex] <= 1'b1;
        dirtyBits[lineIndex] <= 1'b0;   // Fresh fill
      end else if (markDirty) begin
        dirtyBits[lineIndex] <= 1'b1;
      end
      validQ <= validBits[lineIndex];
      dirtyQ <= dirtyBits[lineIndex];
    end
  end

  assign hit = validQ && (victimTag == reqTag);
  assign victimValidDirty = validQ && dirtyQ;   // Needs writeback before refill

endmodule

//--- hw/cachePkg.sv
package cachePkg;

  localparam int defaultNumLines = 8; // 8 lines x 64 B = 512 B

  // Address and data geometry
  localparam int cpuWordWidth = 32;
  localparam int cpuAddrWidth = 30;       // Word address, byte bits dropped
  localparam int wordSelWidth = 2;        // Word within a beat
  localparam int beatSelWidth = 2;        // Beat within a line
  localparam int offsetWidth = wordSelWidth + beatSelWidth;
  localparam int memBeatWidth = 128;
  localparam int memAddrWidth = cpuAddrWidth - wordSelWidth;

  localparam int wordsPerBeat = memBeatWidth / cpuWordWidth;
  localparam int beatsPerLine = 1 << beatSelWidth;

  typedef logic [cpuWordWidth-1:0] cpuWordT;
  typedef logic [cpuAddrWidth-1:0] cpuAddrT;
  typedef logic [cpuWordWidth/8-1:0] byteMaskT;   // All zero means read
  typedef logic [memAddrWidth-1:0] memAddrT;
  typedef logic [memBeatWidth-1:0] memBeatT;
  typedef logic [memBeatWidth/8-1:0] memMaskT;
  typedef logic [beatSelWidth-1:0] beatIndexT;

  // Controller states
  typedef enum logic [2:0] {
    idle,
    tagCheck,
    writebackRead,   // Fetch victim beat from data store
    writebackSend,   // Address and data phases to memory
    fillRequest,
    fillWait,
    relookup         // Registered tag/data read at held address
  } ctrlStateT;

endpackage
